// File: Bender.yml
package:
  name: jtroc_rom_loader

sources:
  - files:
      - verilog/jtroc_mem_pkg.sv
      - verilog/jtroc_dwn_pkg.sv
      - verilog/jtroc_dwn_decode.sv
      - verilog/jtroc_dwn_fifo.sv
      - verilog/jtroc_prom_writer.sv
      - verilog/jtroc_rom_loader.sv
  - target: test
    files:
      - sim/jtroc_tb_clock.sv
      - sim/jtroc_rom_loader_tb.sv

// File: jtroc_rom_loader.f
verilog/jtroc_mem_pkg.sv
verilog/jtroc_dwn_pkg.sv
verilog/jtroc_dwn_decode.sv
verilog/jtroc_dwn_fifo.sv
verilog/jtroc_prom_writer.sv
verilog/jtroc_rom_loader.sv
sim/jtroc_tb_clock.sv
sim/jtroc_rom_loader_tb.sv

// File: sim/jtroc_rom_loader_tb.sv
/*
    ROM download path testbench
    Table of loader bytes with expected SDRAM addresses or PROM
    indexes, a randomly delayed SDRAM acknowledge and FIFO stress
*/

`timescale 1ns/10ps

module jtroc_rom_loader_tb;

localparam int NROWS   = 16;
localparam int TIMEOUT = 200;
localparam int K_SDRAM = 0;
localparam int K_PROM  = 1;
localparam int K_DROP  = 2;

logic        clk;
logic        gen_rst;
logic        tb_rst;
logic [24:0] ioctl_addr;
logic [7:0]  ioctl_dout;
logic        ioctl_wr;
logic        sdram_ack;
logic        sdram_wr;
logic [21:0] sdram_addr;
logic [7:0]  sdram_data;
logic [9:0]  prom_rd_addr;
logic [7:0]  prom_rd_data;
logic        busy;
logic        overflow;

string       row_name [NROWS];
logic [24:0] row_addr [NROWS];
logic [7:0]  row_data [NROWS];
int          row_kind [NROWS];
logic [21:0] row_exp  [NROWS];
logic [7:0]  prom_model [1024];
logic [29:0] obs_q [$];
int          nrows  = 0;
int          errors = 0;
int          checks = 0;
int          seed   = 18;
bit          ack_enable;
logic        held;
logic [29:0] held_word;

jtroc_tb_clock u_clock(
    .clk ( clk     ),
    .rst ( gen_rst )
);

jtroc_rom_loader #(
    .FIFO_DEPTH   ( 8                )
) dut_i(
    .clk          ( clk              ),
    .rst          ( gen_rst | tb_rst ),
    .ioctl_addr   ( ioctl_addr       ),
    .ioctl_dout   ( ioctl_dout       ),
    .ioctl_wr     ( ioctl_wr         ),
    .sdram_ack    ( sdram_ack        ),
    .sdram_wr     ( sdram_wr         ),
    .sdram_addr   ( sdram_addr       ),
    .sdram_data   ( sdram_data       ),
    .prom_rd_addr ( prom_rd_addr     ),
    .prom_rd_data ( prom_rd_data     ),
    .busy         ( busy             ),
    .overflow     ( overflow         )
);

// SDRAM model, acknowledges 0 to 5 cycles after sdram_wr is seen
initial begin : ack_model
    int unsigned delay;
    sdram_ack = 1'b0;
    forever begin
        @(negedge clk);
        if (sdram_wr && ack_enable) begin
            delay = $unsigned($random(seed)) % 6;
            repeat (delay) @(posedge clk);
            @(posedge clk);
            #2;
            sdram_ack = 1'b1;
            @(posedge clk);
            #2;
            sdram_ack = 1'b0;
        end
    end
end

// Records finished writes and watches that a pending write stays put
always @(negedge clk) begin
    if (sdram_wr && held && {sdram_addr, sdram_data} !== held_word) begin
        errors++;
        $display("SDRAM address or data changed while the write waited for sdram_ack");
    end
    if (sdram_wr && sdram_ack) obs_q.push_back({sdram_addr, sdram_data});
    held      = sdram_wr && !sdram_ack;
    held_word = {sdram_addr, sdram_data};
end

task automatic add_row(input string name, input logic [24:0] addr, input logic [7:0] data,
                       input int kind, input logic [21:0] exp_val);
    row_name[nrows] = name;
    row_addr[nrows] = addr;
    row_data[nrows] = data;
    row_kind[nrows] = kind;
    row_exp[nrows]  = exp_val;
    nrows++;
endtask

task automatic send_byte(input logic [24:0] addr, input logic [7:0] data);
    @(posedge clk);
    #2;
    ioctl_addr = addr;
    ioctl_dout = data;
    ioctl_wr   = 1'b1;
    @(posedge clk);
    #2;
    ioctl_wr = 1'b0;
endtask

task automatic set_ack(input bit en);
    @(posedge clk);
    #2;
    ack_enable = en;
endtask

task automatic wait_idle(input string name);
    int n;
    n = 0;
    // Decoder and FIFO need these edges before busy can rise
    repeat (3) @(posedge clk);
    @(negedge clk);
    while (busy !== 1'b0 && n < TIMEOUT) begin
        @(negedge clk);
        n++;
    end
    if (busy !== 1'b0) begin
        errors++;
        $display("Timeout in %s: busy still high after %0d cycles", name, TIMEOUT);
    end
endtask

task automatic wait_sdram_wr(input string name);
    int n;
    n = 0;
    @(negedge clk);
    while (sdram_wr !== 1'b1 && n < TIMEOUT) begin
        @(negedge clk);
        n++;
    end
    if (sdram_wr !== 1'b1) begin
        errors++;
        $display("Timeout in %s: sdram_wr never rose within %0d cycles", name, TIMEOUT);
    end
endtask

task automatic check_count(input string name, input int exp_n);
    checks++;
    if (obs_q.size() != exp_n) begin
        errors++;
        $display("FAILED %s: expected %0d SDRAM writes, actual %0d", name, exp_n, obs_q.size());
    end
endtask

task automatic check_write(input string name, input int idx, input logic [21:0] exp_addr,
                           input logic [7:0] exp_data);
    checks++;
    if (idx >= obs_q.size()) begin
        errors++;
        $display("Missing SDRAM write number %0d in %s", idx, name);
    end else if (obs_q[idx] !== {exp_addr, exp_data}) begin
        errors++;
        $display("FAILED %s: expected addr %h data %h, actual addr %h data %h",
                 name, exp_addr, exp_data, obs_q[idx][29:8], obs_q[idx][7:0]);
    end
endtask

task automatic check_prom(input string name, input logic [9:0] idx);
    logic [7:0] value;
    @(posedge clk);
    #2;
    prom_rd_addr = idx;
    // One cycle of read latency
    @(posedge clk);
    @(negedge clk);
    value = prom_rd_data;
    checks++;
    if (value !== prom_model[idx]) begin
        errors++;
        $display("FAILED %s: PROM[%h] expected %h, actual %h", name, idx, prom_model[idx], value);
    end
endtask

initial begin : main
    int n;
    ioctl_addr   = '0;
    ioctl_dout   = '0;
    ioctl_wr     = 1'b0;
    prom_rd_addr = '0;
    tb_rst       = 1'b0;
    ack_enable   = 1'b1;
    n = 0;
    @(negedge clk);
    while (gen_rst && n < TIMEOUT) begin
        @(negedge clk);
        n++;
    end
    checks++;
    if (gen_rst !== 1'b0 || sdram_wr !== 1'b0 || busy !== 1'b0 || overflow !== 1'b0) begin
        errors++;
        $display("DUT not idle after reset");
    end

    // Expected addresses worked out by hand from the region and swizzle rules
    add_row("main_zero",   25'h0000000, 8'h11, K_SDRAM, 22'h00000);
    add_row("main_mid",    25'h0001234, 8'h22, K_SDRAM, 22'h01234);
    add_row("snd_first",   25'h000A000, 8'h33, K_SDRAM, 22'h0A000);
    add_row("snd_last",    25'h000BFFF, 8'h44, K_SDRAM, 22'h0BFFF);
    add_row("scr_first",   25'h000C000, 8'h55, K_SDRAM, 22'h0C001);
    add_row("scr_mix",     25'h000C00B, 8'h66, K_SDRAM, 22'h0C006);
    add_row("scr_last",    25'h000FFFF, 8'h77, K_SDRAM, 22'h0FFFE);
    add_row("obj_first",   25'h0010000, 8'h88, K_SDRAM, 22'h10003);
    add_row("obj_mix",     25'h001003A, 8'h99, K_SDRAM, 22'h10028);
    add_row("obj_last",    25'h0013FFF, 8'hAA, K_SDRAM, 22'h13FFC);
    add_row("upper_bits",  25'h1000010, 8'h3C, K_SDRAM, 22'h00010);
    add_row("prom_first",  25'h0014000, 8'h5A, K_PROM,  22'h00000);
    add_row("prom_mid",    25'h0014123, 8'hA5, K_PROM,  22'h00123);
    add_row("prom_last",   25'h00143FF, 8'hC3, K_PROM,  22'h003FF);
    // Dropped bytes, PROM index they would alias to
    add_row("past_prom",   25'h0014400, 8'hEE, K_DROP,  22'h00000);
    add_row("far_discard", 25'h03FFFFF, 8'hFF, K_DROP,  22'h003FF);

    for (int i = 0; i < nrows; i++) begin
        obs_q.delete();
        send_byte(row_addr[i], row_data[i]);
        wait_idle(row_name[i]);
        if (row_kind[i] == K_SDRAM) begin
            check_count(row_name[i], 1);
            check_write(row_name[i], 0, row_exp[i], row_data[i]);
        end else begin
            if (row_kind[i] == K_PROM) prom_model[row_exp[i][9:0]] = row_data[i];
            check_count(row_name[i], 0);
            check_prom(row_name[i], row_exp[i][9:0]);
        end
    end

    // Back-pressure, eight writes queue up behind a stalled SDRAM
    obs_q.delete();
    set_ack(1'b0);
    for (int i = 0; i < 8; i++) send_byte(25'h0002000 + i, 8'hB0 + i);
    wait_sdram_wr("backpressure");
    repeat (4) @(posedge clk);
    set_ack(1'b1);
    wait_idle("backpressure");
    check_count("backpressure", 8);
    for (int i = 0; i < 8; i++) check_write("backpressure", i, 22'h02000 + i, 8'hB0 + i);
    checks++;
    if (overflow !== 1'b0) begin
        errors++;
        $display("FAILED backpressure: overflow expected 0, actual %b", overflow);
    end

    // Overflow, eleven bytes against one pending write and eight FIFO slots
    obs_q.delete();
    set_ack(1'b0);
    for (int i = 0; i < 11; i++) send_byte(25'h0003000 + i, 8'hC0 + i);
    repeat (3) @(posedge clk);
    @(negedge clk);
    checks++;
    if (overflow !== 1'b1) begin
        errors++;
        $display("FAILED overflow: overflow expected 1, actual %b", overflow);
    end
    set_ack(1'b1);
    wait_idle("overflow");
    checks++;
    if (obs_q.size() == 0 || obs_q.size() >= 11) begin
        errors++;
        $display("FAILED overflow: expected 1 to 10 writes, actual %0d", obs_q.size());
    end
    for (int i = 0; i < obs_q.size() && i < 11; i++) begin
        check_write("overflow", i, 22'h03000 + i, 8'hC0 + i);
    end

    @(posedge clk);
    #2;
    tb_rst = 1'b1;
    repeat (2) @(posedge clk);
    #2;
    tb_rst = 1'b0;
    @(negedge clk);
    checks++;
    if (overflow !== 1'b0 || busy !== 1'b0) begin
        errors++;
        $display("FAILED reset: expected overflow 0 busy 0, actual overflow %b busy %b",
                 overflow, busy);
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
        $display("RESULT: PASS");
    end else begin
        $display("RESULT: FAIL");
    end
    $finish;
end

endmodule

// File: sim/jtroc_tb_clock.sv
/*
    Testbench clock and reset
    Free running clock with reset held for the first cycles
*/

`timescale 1ns/10ps

module jtroc_tb_clock #(
    parameter real PERIOD     = 20.0,
    parameter int  RST_CYCLES = 8
)(
    output logic clk,
    output logic rst
);

initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
end

// Released just after an edge, like the rest of the stimulus
initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #2;
    rst = 1'b0;
end

endmodule

// File: verilog/jtroc_dwn_decode.sv
/*
    Download byte decoder
    Classifies each loader byte by ROM region, reorders the low
    address bits of graphics ROMs and registers the result
*/

`timescale 1ns/10ps

module jtroc_dwn_decode(
    input                            clk,
    input                            rst,
    input        [24:0]              ioctl_addr,
    input        [ 7:0]              ioctl_dout,
    input                            ioctl_wr,
    output logic                     push,
    output jtroc_dwn_pkg::dwn_word_t word
);

// First byte past the colour PROMs
localparam logic [jtroc_mem_pkg::SDRAM_AW-1:0] PROM_END =
    jtroc_mem_pkg::PROM_START + (1 << jtroc_mem_pkg::PROM_AW);

logic [jtroc_mem_pkg::SDRAM_AW-1:0] raw_addr;
logic [jtroc_mem_pkg::SDRAM_AW-1:0] prom_ofs;
jtroc_dwn_pkg::dwn_word_t           next_word;
logic                               keep;

// Only the low 22 bits select the region
assign raw_addr = ioctl_addr[jtroc_mem_pkg::SDRAM_AW-1:0];
assign prom_ofs = raw_addr - jtroc_mem_pkg::PROM_START;

always_comb begin
    keep             = 1'b1;
    next_word.region = jtroc_mem_pkg::REG_MAIN;
    next_word.addr   = raw_addr;
    next_word.data   = ioctl_dout;
    if (raw_addr >= PROM_END) begin
        // Past the PROMs, nothing to store
        keep = 1'b0;
    end else if (raw_addr >= jtroc_mem_pkg::PROM_START) begin
        next_word.region = jtroc_mem_pkg::REG_PROM;
        next_word.addr   = prom_ofs;
    end else if (raw_addr >= jtroc_mem_pkg::OBJ_START) begin
        // Object fetch order, bit 5 stays in place
        next_word.region    = jtroc_mem_pkg::REG_OBJ;
        next_word.addr[0]   = ~raw_addr[3];
        next_word.addr[1]   = ~raw_addr[4];
        next_word.addr[4:2] = raw_addr[2:0];
    end else if (raw_addr >= jtroc_mem_pkg::SCR_START) begin
        // Scroll tile fetch order
        next_word.region    = jtroc_mem_pkg::REG_SCR;
        next_word.addr[0]   = ~raw_addr[3];
        next_word.addr[3:1] = raw_addr[2:0];
    end else if (raw_addr >= jtroc_mem_pkg::SND_START) begin
        next_word.region = jtroc_mem_pkg::REG_SND;
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        push <= 1'b0;
    end else begin
        push <= ioctl_wr & keep;
    end
end

// Payload follows the strobe by the same cycle
always_ff @(posedge clk) begin
    word <= next_word;
end

endmodule

// File: verilog/jtroc_dwn_fifo.sv
/*
    Download word FIFO
    Synchronous register FIFO between decoder and writer,
    with a sticky flag for pushes that arrive while full
*/

`timescale 1ns/10ps

module jtroc_dwn_fifo #(
    parameter int DEPTH = 8
)(
    input                            clk,
    input                            rst,
    input                            push,
    input  jtroc_dwn_pkg::dwn_word_t din,
    input                            pop,
    output jtroc_dwn_pkg::dwn_word_t dout,
    output logic                     empty,
    output logic                     overflow
);

localparam int AW = $clog2(DEPTH);
localparam logic [AW:0] FULL_CNT = (AW+1)'(DEPTH);

jtroc_dwn_pkg::dwn_word_t mem [DEPTH];

logic [AW-1:0] wr_ptr;
logic [AW-1:0] rd_ptr;
logic [AW:0]   count;
logic          full;
logic          wr_en;
logic          rd_en;

assign full  = count == FULL_CNT;
assign empty = count == '0;
assign wr_en = push & ~full;
assign rd_en = pop & ~empty;

// Head word is visible without a read cycle
assign dout = mem[rd_ptr];

always_ff @(posedge clk) begin
    if (rst) begin
        wr_ptr   <= '0;
        rd_ptr   <= '0;
        count    <= '0;
        overflow <= 1'b0;
    end else begin
        if (wr_en) wr_ptr <= wr_ptr + 1'b1;
        if (rd_en) rd_ptr <= rd_ptr + 1'b1;
        case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
        endcase
        // Dropped word, held until reset
        if (push && full) overflow <= 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (wr_en) mem[wr_ptr] <= din;
end

endmodule

// File: verilog/jtroc_dwn_pkg.sv
/*
    ROM download transfer types
    Word passed from the decoder through the FIFO to the writer
*/

package jtroc_dwn_pkg;

    // Width of one download byte
    localparam int DATA_W = 8;

    // One classified download byte
    // addr already swizzled, or the PROM offset for PROM bytes
    typedef struct packed {
        jtroc_mem_pkg::region_t                region;
        logic [jtroc_mem_pkg::SDRAM_AW-1:0]    addr;
        logic [DATA_W-1:0]                     data;
    } dwn_word_t;

endpackage

// File: verilog/jtroc_mem_pkg.sv
/*
    ROM download memory map
    SDRAM byte offsets of each ROM region, address widths
    and the region codes used along the download path
*/

package jtroc_mem_pkg;

    // SDRAM byte address width
    localparam int SDRAM_AW = 22;

    // Colour PROM address width, 1024 bytes in total
    localparam int PROM_AW = 10;

    // Region offsets in the download stream
    // Main CPU ROM starts at zero
    localparam logic [SDRAM_AW-1:0] SND_START  = 22'h0A000;
    localparam logic [SDRAM_AW-1:0] SCR_START  = 22'h0C000;
    localparam logic [SDRAM_AW-1:0] OBJ_START  = 22'h10000;
    localparam logic [SDRAM_AW-1:0] PROM_START = 22'h14000;

    // Memory region of a download byte
    typedef enum logic [2:0] {
        REG_MAIN,
        REG_SND,
        REG_SCR,
        REG_OBJ,
        REG_PROM
    } region_t;

endpackage

// File: verilog/jtroc_prom_writer.sv
/*
    Download writer
    Stores colour PROM bytes on chip and presents every other
    byte as an SDRAM write held until the memory acknowledges it
*/

`timescale 1ns/10ps

module jtroc_prom_writer(
    input                                       clk,
    input                                       rst,
    input                                       empty,
    input  jtroc_dwn_pkg::dwn_word_t            head,
    output logic                                pop,
    input                                       sdram_ack,
    output logic                                sdram_wr,
    output logic [jtroc_mem_pkg::SDRAM_AW-1:0]  sdram_addr,
    output logic [ 7:0]                         sdram_data,
    input        [jtroc_mem_pkg::PROM_AW-1:0]   prom_rd_addr,
    output logic [ 7:0]                         prom_rd_data
);

typedef enum logic {
    ST_IDLE,
    ST_WAIT
} wr_state_t;

wr_state_t  state;
logic [7:0] prom [1 << jtroc_mem_pkg::PROM_AW];
logic       is_prom;

assign is_prom  = head.region == jtroc_mem_pkg::REG_PROM;
assign sdram_wr = state == ST_WAIT;

// No pop while an SDRAM write is pending
assign pop = (state == ST_IDLE) & ~empty;

always_ff @(posedge clk) begin
    if (rst) begin
        state <= ST_IDLE;
    end else begin
        case (state)
            ST_IDLE: begin
                if (pop && !is_prom) state <= ST_WAIT;
            end
            ST_WAIT: begin
                if (sdram_ack) state <= ST_IDLE;
            end
            default: state <= ST_IDLE;
        endcase
    end
end

// Address and data stay put while sdram_wr is high
always_ff @(posedge clk) begin
    if (pop && !is_prom) begin
        sdram_addr <= head.addr;
        sdram_data <= head.data;
    end
end

// PROM written in the pop cycle itself
always_ff @(posedge clk) begin
    if (pop && is_prom) prom[head.addr[jtroc_mem_pkg::PROM_AW-1:0]] <= head.data;
    prom_rd_data <= prom[prom_rd_addr];
end

endmodule

// File: verilog/jtroc_rom_loader.sv
/*
    ROM download path
    Loader byte stream through decoder, FIFO and writer
    into the colour PROMs or SDRAM
*/

`timescale 1ns/10ps

module jtroc_rom_loader #(
    parameter int FIFO_DEPTH = 8
)(
    input                                   clk,
    input                                   rst,
    // Loader stream
    input  [24:0]                           ioctl_addr,
    input  [ 7:0]                           ioctl_dout,
    input                                   ioctl_wr,
    // SDRAM write port
    input                                   sdram_ack,
    output                                  sdram_wr,
    output [jtroc_mem_pkg::SDRAM_AW-1:0]    sdram_addr,
    output [ 7:0]                           sdram_data,
    // Colour PROM read port
    input  [jtroc_mem_pkg::PROM_AW-1:0]     prom_rd_addr,
    output [ 7:0]                           prom_rd_data,
    // Status
    output                                  busy,
    output                                  overflow
);

jtroc_dwn_pkg::dwn_word_t dec_word;
jtroc_dwn_pkg::dwn_word_t head_word;
logic                     push;
logic                     pop;
logic                     empty;

assign busy = ~empty | sdram_wr;

jtroc_dwn_decode u_decode(
    .clk        ( clk           ),
    .rst        ( rst           ),
    .ioctl_addr ( ioctl_addr    ),
    .ioctl_dout ( ioctl_dout    ),
    .ioctl_wr   ( ioctl_wr      ),
    .push       ( push          ),
    .word       ( dec_word      )
);

jtroc_dwn_fifo #(
    .DEPTH      ( FIFO_DEPTH    )
) u_fifo(
    .clk        ( clk           ),
    .rst        ( rst           ),
    .push       ( push          ),
    .din        ( dec_word      ),
    .pop        ( pop           ),
    .dout       ( head_word     ),
    .empty      ( empty         ),
    .overflow   ( overflow      )
);

jtroc_prom_writer u_writer(
    .clk          ( clk          ),
    .rst          ( rst          ),
    .empty        ( empty        ),
    .head         ( head_word    ),
    .pop          ( pop          ),
    .sdram_ack    ( sdram_ack    ),
    .sdram_wr     ( sdram_wr     ),
    .sdram_addr   ( sdram_addr   ),
    .sdram_data   ( sdram_data   ),
    .prom_rd_addr ( prom_rd_addr ),
    .prom_rd_data ( prom_rd_data )
);

endmodule
